// ==== rtl/stat_pkg.sv ====
package stat_pkg;

    // Block length and bus geometry
    localparam int n_samples  = 40;
    localparam int apb_addr_w = 8;

    // Register map
    localparam logic [apb_addr_w-1:0] reg_ctrl        = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_status      = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_mean        = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_std         = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_variance    = 8'h10;
    localparam logic [apb_addr_w-1:0] reg_block_count = 8'h14;

    // One sample, also the width of the mean
    typedef logic [15:0] sample_t;
    // Sum of 40 samples
    typedef logic [21:0] sum_t;
    // Sum of 40 squared deviations
    typedef logic [37:0] sq_sum_t;
    typedef logic [31:0] variance_t;
    typedef logic [15:0] std_t;
    typedef logic [31:0] count_t;
    typedef logic [31:0] apb_data_t;

    // Statistics core sequencing
    typedef enum logic [1:0] {
        core_idle,
        core_root,
        core_done
    } core_state_t;

    // Square root iteration
    typedef enum logic {
        root_idle,
        root_run
    } root_state_t;

endpackage

// ==== rtl/stat_result_if.sv ====
interface stat_result_if;

    // Single-cycle pulse, no back-pressure
    logic                result_valid;
    stat_pkg::sample_t   mean;
    stat_pkg::std_t      std;
    stat_pkg::variance_t variance;

    modport core (
        output result_valid,
        output mean,
        output std,
        output variance
    );

    modport regs (
        input result_valid,
        input mean,
        input std,
        input variance
    );

endinterface

// ==== rtl/sample_window.sv ====
module sample_window (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  logic              flush,
    input  logic              sample_valid,
    input  stat_pkg::sample_t sample_data,
    output logic              sample_ready,
    output logic              block_valid,
    input  logic              block_ready,
    output stat_pkg::sample_t block_data [0:stat_pkg::n_samples-1]
);

    logic [$clog2(stat_pkg::n_samples)-1:0] fill_q;
    logic                                   full_q;
    logic                                   sample_acc;
    logic                                   block_acc;

    // Stall the source while disabled or while a full block is pending
    assign sample_ready = enable && !full_q;
    assign sample_acc   = sample_valid && sample_ready;

    assign block_valid = full_q;
    assign block_acc   = block_valid && block_ready;

    // Fill counter and full flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_q <= '0;
            full_q <= 1'b0;
        end else if (flush) begin
            // Drop partial or waiting block
            fill_q <= '0;
            full_q <= 1'b0;
        end else if (block_acc) begin
            fill_q <= '0;
            full_q <= 1'b0;
        end else if (sample_acc) begin
            if (fill_q == stat_pkg::n_samples - 1) begin
                fill_q <= '0;
                full_q <= 1'b1;
            end else begin
                fill_q <= fill_q + 1'b1;
            end
        end
    end

    // Block buffer, one slot per accepted sample
    always_ff @(posedge clk) begin
        if (sample_acc) begin
            block_data[fill_q] <= sample_data;
        end
    end

endmodule

// ==== rtl/isqrt_unit.sv ====
module isqrt_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  stat_pkg::variance_t radicand,
    output stat_pkg::std_t      root,
    output logic                root_done
);

    stat_pkg::root_state_t state_q;
    stat_pkg::variance_t   rad_q;
    logic [17:0]           rem_q;
    logic [3:0]            step_q;
    logic [19:0]           rem_trial;
    logic [19:0]           sub_val;
    logic [19:0]           rem_diff;
    logic                  fits;

    // Bring down the next two radicand bits and try 4*root+1
    assign rem_trial = {rem_q, rad_q[31:30]};
    assign sub_val   = {2'b00, root, 2'b01};
    assign rem_diff  = rem_trial - sub_val;
    assign fits      = rem_trial >= sub_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= stat_pkg::root_idle;
            step_q    <= '0;
            root_done <= 1'b0;
        end else begin
            root_done <= 1'b0;
            case (state_q)
                stat_pkg::root_idle: begin
                    if (start) begin
                        state_q <= stat_pkg::root_run;
                        step_q  <= '0;
                    end
                end
                stat_pkg::root_run: begin
                    step_q <= step_q + 1'b1;
                    // Sixteen iterations for a 32-bit radicand
                    if (step_q == 4'd15) begin
                        state_q   <= stat_pkg::root_idle;
                        root_done <= 1'b1;
                    end
                end
                default: state_q <= stat_pkg::root_idle;
            endcase
        end
    end

    // Restoring datapath
    always_ff @(posedge clk) begin
        if (state_q == stat_pkg::root_idle && start) begin
            rad_q <= radicand;
            rem_q <= '0;
            root  <= '0;
        end else if (state_q == stat_pkg::root_run) begin
            rad_q <= rad_q << 2;
            if (fits) begin
                rem_q <= rem_diff[17:0];
                root  <= {root[14:0], 1'b1};
            end else begin
                rem_q <= rem_trial[17:0];
                root  <= {root[14:0], 1'b0};
            end
        end
    end

endmodule

// ==== rtl/mean_std.sv ====
module mean_std (
    input  logic              clk,
    input  logic              rst,
    input  logic              block_valid,
    input  stat_pkg::sample_t block_data [0:stat_pkg::n_samples-1],
    output logic              block_ready,
    stat_result_if.core       res
);

    stat_pkg::core_state_t state_q;
    stat_pkg::sum_t        sum;
    stat_pkg::sample_t     mean_comb;
    stat_pkg::sq_sum_t     sq_sum;
    stat_pkg::variance_t   var_comb;
    logic signed [16:0]    dev;
    logic signed [33:0]    dev_sq;
    stat_pkg::sample_t     mean_q;
    stat_pkg::variance_t   var_q;
    stat_pkg::std_t        root;
    logic                  start_q;
    logic                  root_done;
    logic                  accept;

    // One block in the core at a time
    assign block_ready = (state_q == stat_pkg::core_idle);
    assign accept      = block_valid && block_ready;

    // Sum, floor mean and squared deviations of the offered block
    always_comb begin
        sum = '0;
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            sum = sum + stat_pkg::sum_t'(block_data[i]);
        end
        mean_comb = stat_pkg::sample_t'(sum / stat_pkg::n_samples);

        sq_sum = '0;
        dev    = '0;
        dev_sq = '0;
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            dev    = $signed({1'b0, block_data[i]}) - $signed({1'b0, mean_comb});
            dev_sq = dev * dev;
            sq_sum = sq_sum + stat_pkg::sq_sum_t'(dev_sq);
        end
        var_comb = stat_pkg::variance_t'(sq_sum / stat_pkg::n_samples);
    end

    // Result registers
    always_ff @(posedge clk) begin
        if (accept) begin
            mean_q <= mean_comb;
            var_q  <= var_comb;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= stat_pkg::core_idle;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                stat_pkg::core_idle: begin
                    if (accept) begin
                        state_q <= stat_pkg::core_root;
                        start_q <= 1'b1;
                    end
                end
                stat_pkg::core_root: begin
                    if (root_done) begin
                        state_q <= stat_pkg::core_done;
                    end
                end
                stat_pkg::core_done: state_q <= stat_pkg::core_idle;
                default:             state_q <= stat_pkg::core_idle;
            endcase
        end
    end

    isqrt_unit u_isqrt (
        .clk       (clk),
        .rst       (rst),
        .start     (start_q),
        .radicand  (var_q),
        .root      (root),
        .root_done (root_done)
    );

    // Pulse lasts the single cycle spent in core_done
    assign res.result_valid = (state_q == stat_pkg::core_done);
    assign res.mean         = mean_q;
    assign res.variance     = var_q;
    assign res.std          = root;

endmodule

// ==== rtl/stat_regs.sv ====
module stat_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [stat_pkg::apb_addr_w-1:0]  paddr,
    input  stat_pkg::apb_data_t              pwdata,
    output stat_pkg::apb_data_t              prdata,
    output logic                             pready,
    output logic                             pslverr,
    stat_result_if.regs                      res,
    output logic                             enable,
    output logic                             flush
);

    logic                result_ready_q;
    logic                overrun_q;
    stat_pkg::sample_t   mean_q;
    stat_pkg::std_t      std_q;
    stat_pkg::variance_t var_q;
    stat_pkg::count_t    count_q;
    logic                access;
    logic                mapped;
    logic                ctrl_wr;
    logic                status_wr;

    // No wait states
    assign pready = 1'b1;

    assign access    = psel && penable;
    assign ctrl_wr   = access && pwrite && (paddr == stat_pkg::reg_ctrl);
    assign status_wr = access && pwrite && (paddr == stat_pkg::reg_status);
    assign pslverr   = access && !mapped;

    // Read mux and address decode
    always_comb begin
        mapped = 1'b1;
        case (paddr)
            stat_pkg::reg_ctrl:        prdata = {31'b0, enable};
            stat_pkg::reg_status:      prdata = {30'b0, overrun_q, result_ready_q};
            stat_pkg::reg_mean:        prdata = stat_pkg::apb_data_t'(mean_q);
            stat_pkg::reg_std:         prdata = stat_pkg::apb_data_t'(std_q);
            stat_pkg::reg_variance:    prdata = var_q;
            stat_pkg::reg_block_count: prdata = count_q;
            default: begin
                prdata = '0;
                mapped = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable         <= 1'b0;
            flush          <= 1'b0;
            result_ready_q <= 1'b0;
            overrun_q      <= 1'b0;
            mean_q         <= '0;
            std_q          <= '0;
            var_q          <= '0;
            count_q        <= '0;
        end else begin
            // Flush bit is self-clearing
            flush <= ctrl_wr && pwdata[1];
            if (ctrl_wr) begin
                enable <= pwdata[0];
            end

            // W1C on status
            if (status_wr) begin
                if (pwdata[0]) begin
                    result_ready_q <= 1'b0;
                end
                if (pwdata[1]) begin
                    overrun_q <= 1'b0;
                end
            end

            // New result wins over a clear in the same cycle
            if (res.result_valid) begin
                mean_q         <= res.mean;
                std_q          <= res.std;
                var_q          <= res.variance;
                count_q        <= count_q + 1'b1;
                result_ready_q <= 1'b1;
                if (result_ready_q) begin
                    overrun_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/stat_monitor.sv ====
module stat_monitor (
    input  logic                             clk,
    input  logic                             rst,
    // Sample stream
    input  logic                             sample_valid,
    input  stat_pkg::sample_t                sample_data,
    output logic                             sample_ready,
    // APB slave
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [stat_pkg::apb_addr_w-1:0]  paddr,
    input  stat_pkg::apb_data_t              pwdata,
    output stat_pkg::apb_data_t              prdata,
    output logic                             pready,
    output logic                             pslverr
);

    logic              block_valid;
    logic              block_ready;
    stat_pkg::sample_t block_data [0:stat_pkg::n_samples-1];
    logic              enable;
    logic              flush;

    stat_result_if res_if ();

    sample_window u_window (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .flush        (flush),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .sample_ready (sample_ready),
        .block_valid  (block_valid),
        .block_ready  (block_ready),
        .block_data   (block_data)
    );

    // Statistics core, holds the second block in flight
    mean_std u_core (
        .clk         (clk),
        .rst         (rst),
        .block_valid (block_valid),
        .block_data  (block_data),
        .block_ready (block_ready),
        .res         (res_if.core)
    );

    stat_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .res     (res_if.regs),
        .enable  (enable),
        .flush   (flush)
    );

endmodule

// ==== testbench/tb_stat_monitor.sv ====
module tb_stat_monitor;

    timeunit 1ns;
    timeprecision 1ps;

    // Samples streamed over the whole run, sizes the watchdog
    localparam int total_samples   = 40 + 4 * 40 + 3 * 40 + 17 + 40;
    localparam int watchdog_cycles = total_samples * 20 + 2000;

    logic                            clk;
    logic                            rst;
    logic                            sample_valid;
    stat_pkg::sample_t               sample_data;
    logic                            sample_ready;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [stat_pkg::apb_addr_w-1:0] paddr;
    stat_pkg::apb_data_t             pwdata;
    stat_pkg::apb_data_t             prdata;
    logic                            pready;
    logic                            pslverr;

    stat_pkg::sample_t   stim [$];
    logic [31:0]         rng_state;
    stat_pkg::sample_t   exp_mean;
    stat_pkg::variance_t exp_var;
    stat_pkg::std_t      exp_std;
    stat_pkg::count_t    exp_count;

    stat_monitor UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_mismatch(input string what, input longint got, input longint exp);
        stop_with_failure($sformatf("Mismatch at %0d ns: %s got 0x%0h, expected 0x%0h",
                                    $time, what, got, exp));
    endtask

    task automatic check_mean(stat_pkg::sample_t got, stat_pkg::sample_t exp, string what);
        if (got !== exp) begin
            report_mismatch({what, " mean"}, got, exp);
        end
    endtask

    task automatic check_std(stat_pkg::std_t got, stat_pkg::std_t exp, string what);
        if (got !== exp) begin
            report_mismatch({what, " std"}, got, exp);
        end
    endtask

    task automatic check_variance(stat_pkg::variance_t got, stat_pkg::variance_t exp, string what);
        if (got !== exp) begin
            report_mismatch({what, " variance"}, got, exp);
        end
    endtask

    task automatic check_count(stat_pkg::count_t got, stat_pkg::count_t exp, string what);
        if (got !== exp) begin
            report_mismatch({what, " block count"}, got, exp);
        end
    endtask

    task automatic check_word(stat_pkg::apb_data_t got, stat_pkg::apb_data_t exp, string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    // LCG, upper half of the state gives the sample
    function automatic stat_pkg::sample_t next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    // Reference model over the 40 samples starting at base
    task automatic compute_expected(input int base);
        longint total;
        longint avg;
        longint dev;
        longint sq_total;
        longint variance;
        longint cand;
        total    = 0;
        sq_total = 0;
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            total = total + longint'(stim[base + i]);
        end
        avg = total / stat_pkg::n_samples;
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            dev      = longint'(stim[base + i]) - avg;
            sq_total = sq_total + dev * dev;
        end
        variance = sq_total / stat_pkg::n_samples;
        // Largest candidate whose square still fits
        cand = 0;
        while ((cand + 1) * (cand + 1) <= variance) begin
            cand = cand + 1;
        end
        exp_mean = stat_pkg::sample_t'(avg);
        exp_var  = stat_pkg::variance_t'(variance);
        exp_std  = stat_pkg::std_t'(cand);
    endtask

    task automatic apb_write(input logic [7:0] addr, input stat_pkg::apb_data_t data,
                             input logic exp_err);
        logic err;
        logic rdy;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        rdy = pready;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        check_bit(rdy, 1'b1, $sformatf("pready on write to 0x%02h", addr));
        check_bit(err, exp_err, $sformatf("pslverr on write to 0x%02h", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output stat_pkg::apb_data_t data,
                            input logic exp_err);
        logic err;
        logic rdy;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err  = pslverr;
        rdy  = pready;
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        check_bit(rdy, 1'b1, $sformatf("pready on read from 0x%02h", addr));
        check_bit(err, exp_err, $sformatf("pslverr on read from 0x%02h", addr));
    endtask

    // Each sample is held until an edge that sees sample_ready high
    task automatic send_block();
        @(posedge clk);
        foreach (stim[i]) begin
            sample_valid <= 1'b1;
            sample_data  <= stim[i];
            @(negedge clk);
            while (!sample_ready) begin
                @(negedge clk);
            end
            @(posedge clk);
        end
        sample_valid <= 1'b0;
    endtask

    task automatic wait_result();
        stat_pkg::apb_data_t status;
        status = '0;
        while (status[0] !== 1'b1) begin
            apb_read(stat_pkg::reg_status, status, 1'b0);
        end
    endtask

    task automatic wait_count(input stat_pkg::count_t target);
        stat_pkg::apb_data_t count;
        count = '0;
        while (count !== target) begin
            apb_read(stat_pkg::reg_block_count, count, 1'b0);
        end
    endtask

    task automatic check_results(input string what);
        stat_pkg::apb_data_t data;
        apb_read(stat_pkg::reg_mean, data, 1'b0);
        check_mean(stat_pkg::sample_t'(data), exp_mean, what);
        apb_read(stat_pkg::reg_std, data, 1'b0);
        check_std(stat_pkg::std_t'(data), exp_std, what);
        apb_read(stat_pkg::reg_variance, data, 1'b0);
        check_variance(data, exp_var, what);
        apb_read(stat_pkg::reg_block_count, data, 1'b0);
        check_count(data, exp_count, what);
    endtask

    // Stream stim as one block, compare, then clear STATUS
    task automatic run_single_block(input string what);
        stat_pkg::apb_data_t data;
        send_block();
        compute_expected(0);
        exp_count = exp_count + 1;
        wait_result();
        check_results(what);
        apb_read(stat_pkg::reg_status, data, 1'b0);
        check_word(data, 32'h1, {what, " status"});
        apb_write(stat_pkg::reg_status, 32'h3, 1'b0);
    endtask

    task automatic reset_values_read_zero();
        stat_pkg::apb_data_t data;
        @(posedge clk);
        sample_valid <= 1'b1;
        sample_data  <= 16'h1234;
        repeat (10) begin
            @(negedge clk);
            check_bit(sample_ready, 1'b0, "sample_ready while disabled");
        end
        @(posedge clk);
        sample_valid <= 1'b0;
        exp_mean = '0;
        exp_std  = '0;
        exp_var  = '0;
        check_results("after reset");
        apb_read(stat_pkg::reg_ctrl, data, 1'b0);
        check_word(data, 32'h0, "CTRL after reset");
        apb_read(stat_pkg::reg_status, data, 1'b0);
        check_word(data, 32'h0, "STATUS after reset");
    endtask

    task automatic constant_block();
        apb_write(stat_pkg::reg_ctrl, 32'h1, 1'b0);
        stim.delete();
        repeat (stat_pkg::n_samples) stim.push_back(16'd1000);
        run_single_block("constant block");
    endtask

    task automatic random_and_extreme_blocks();
        for (int b = 0; b < 3; b++) begin
            stim.delete();
            repeat (stat_pkg::n_samples) stim.push_back(next_random());
            run_single_block($sformatf("random block %0d", b));
        end
        stim.delete();
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            stim.push_back((i % 2 == 0) ? 16'd0 : 16'hFFFF);
        end
        run_single_block("alternating extremes");
    endtask

    task automatic back_to_back_blocks();
        stat_pkg::apb_data_t data;
        stim.delete();
        repeat (3 * stat_pkg::n_samples) stim.push_back(next_random());
        send_block();
        exp_count = exp_count + 3;
        wait_count(exp_count);
        compute_expected(2 * stat_pkg::n_samples);
        check_results("third of three blocks");
        apb_read(stat_pkg::reg_status, data, 1'b0);
        check_word(data, 32'h3, "STATUS with overrun");
        apb_write(stat_pkg::reg_status, 32'h3, 1'b0);
        apb_read(stat_pkg::reg_status, data, 1'b0);
        check_word(data, 32'h0, "STATUS after clear");
    endtask

    task automatic flush_partial_block();
        stat_pkg::apb_data_t data;
        stim.delete();
        repeat (17) stim.push_back(next_random());
        send_block();
        // Keep enable set while pulsing flush
        apb_write(stat_pkg::reg_ctrl, 32'h3, 1'b0);
        apb_read(stat_pkg::reg_ctrl, data, 1'b0);
        check_word(data, 32'h1, "CTRL after flush");
        stim.delete();
        for (int i = 0; i < stat_pkg::n_samples; i++) begin
            stim.push_back(stat_pkg::sample_t'(500 + i * 37));
        end
        run_single_block("block after flush");
    endtask

    task automatic unmapped_access();
        stat_pkg::apb_data_t data;
        apb_read(8'h18, data, 1'b1);
        // A write that would clear enable if it reached CTRL
        apb_write(8'h20, 32'h0, 1'b1);
        apb_write(8'h1C, 32'h3, 1'b1);
        check_results("after unmapped access");
        apb_read(stat_pkg::reg_ctrl, data, 1'b0);
        check_word(data, 32'h1, "CTRL after unmapped access");
        apb_read(stat_pkg::reg_status, data, 1'b0);
        check_word(data, 32'h0, "STATUS after unmapped access");
    endtask

    initial begin
        rst          = 1'b1;
        sample_valid = 1'b0;
        sample_data  = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        rng_state    = 32'd3592;
        exp_count    = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        reset_values_read_zero();
        constant_block();
        random_and_extreme_blocks();
        back_to_back_blocks();
        flush_partial_block();
        unmapped_access();
        $display("RESULT: PASS");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        stop_with_failure($sformatf("Timeout: tests did not finish within %0d cycles",
                                    watchdog_cycles));
    end

endmodule

// ==== stat_monitor.f ====
rtl/stat_pkg.sv
rtl/stat_result_if.sv
rtl/sample_window.sv
rtl/isqrt_unit.sv
rtl/mean_std.sv
rtl/stat_regs.sv
rtl/stat_monitor.sv
testbench/tb_stat_monitor.sv
